/* axi_pkg.sv */
`default_nettype none

package axi_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = 4;
    localparam int id_w   = 4;
    localparam int size_w = 3;

    // read ids, one per sram port
    localparam logic [id_w-1:0] id_inst = 4'd0;
    localparam logic [id_w-1:0] id_data = 4'd1;

    // id bit that routes a response back to its port
    localparam int id_port_bit = 0;

endpackage

`default_nettype wire

/* bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

    // sram side size field
    localparam int sram_size_w = 2;

    // outstanding counters saturate at three
    localparam int cnt_w = 2;

    // read request fsm, one-hot
    localparam logic [3:0] rq_idle  = 4'b0001;
    localparam logic [3:0] rq_check = 4'b0010;
    localparam logic [3:0] rq_issue = 4'b0100;
    localparam logic [3:0] rq_done  = 4'b1000;

    // write request fsm, one-hot
    localparam logic [2:0] wq_idle  = 3'b001;
    localparam logic [2:0] wq_issue = 3'b010;
    localparam logic [2:0] wq_done  = 3'b100;

endpackage

`default_nettype wire

/* read_request.sv */
`timescale 1ns/1ps
`default_nettype none

module read_request
    import axi_pkg::*, bridge_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   inst_en,
    input  logic [sram_size_w-1:0] inst_size,
    input  logic [addr_w-1:0]      inst_addr,
    input  logic                   data_en,
    input  logic                   data_wr,
    input  logic [sram_size_w-1:0] data_size,
    input  logic [addr_w-1:0]      data_addr,
    input  logic                   write_busy,
    input  logic                   inst_full,
    input  logic                   data_full,
    input  logic                   arready,
    output logic [id_w-1:0]        arid,
    output logic [addr_w-1:0]      araddr,
    output logic [size_w-1:0]      arsize,
    output logic                   arvalid,
    output logic                   ar_fire,
    output logic                   inst_addr_ok,
    output logic                   data_read_addr_ok
);

    logic [3:0] state;
    logic [3:0] state_next;
    logic       take_data;
    logic       take_inst;

    // data reads win, a full port is skipped
    assign take_data = data_en && !data_wr && !data_full;
    assign take_inst = inst_en && !inst_full && !take_data;

    always_comb begin
        state_next = state;
        case (state)
            rq_idle: begin
                if (take_data) begin
                    state_next = rq_check;
                end else if (take_inst) begin
                    state_next = rq_issue;
                end
            end
            // hold a data read until pending writes are answered
            rq_check: begin
                if (!write_busy) begin
                    state_next = rq_issue;
                end
            end
            rq_issue: begin
                if (ar_fire) begin
                    state_next = rq_done;
                end
            end
            rq_done: state_next = rq_idle;
            default: state_next = rq_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= rq_idle;
        end else begin
            state <= state_next;
        end
    end

    // request fields are stable until addr_ok, so latch them once
    always_ff @(posedge clk) begin
        if (state == rq_idle) begin
            if (take_data) begin
                arid   <= id_data;
                araddr <= data_addr;
                arsize <= {{(size_w-sram_size_w){1'b0}}, data_size};
            end else if (take_inst) begin
                arid   <= id_inst;
                araddr <= inst_addr;
                arsize <= {{(size_w-sram_size_w){1'b0}}, inst_size};
            end
        end
    end

    assign arvalid = (state == rq_issue);
    assign ar_fire = arvalid && arready;

    assign inst_addr_ok      = (state == rq_done) && !arid[id_port_bit];
    assign data_read_addr_ok = (state == rq_done) && arid[id_port_bit];

endmodule

`default_nettype wire

/* read_response.sv */
`timescale 1ns/1ps
`default_nettype none

module read_response
    import axi_pkg::*, bridge_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              ar_fire,
    input  logic [id_w-1:0]   arid,
    input  logic [id_w-1:0]   rid,
    input  logic [data_w-1:0] rdata,
    input  logic              rvalid,
    output logic              rready,
    output logic              inst_full,
    output logic              data_full,
    output logic [data_w-1:0] inst_rdata,
    output logic              inst_data_ok,
    output logic [data_w-1:0] data_rdata,
    output logic              data_read_data_ok
);

    logic [cnt_w-1:0] cnt_inst;
    logic [cnt_w-1:0] cnt_data;
    logic             r_fire;
    logic             inc_inst;
    logic             inc_data;
    logic             dec_inst;
    logic             dec_data;

    assign r_fire = rvalid && rready;

    // issue side counts up, return side counts down
    assign inc_inst = ar_fire && !arid[id_port_bit];
    assign inc_data = ar_fire && arid[id_port_bit];
    assign dec_inst = r_fire && !rid[id_port_bit];
    assign dec_data = r_fire && rid[id_port_bit];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt_inst <= '0;
            cnt_data <= '0;
        end else begin
            // same id on both sides nets to zero
            cnt_inst <= cnt_inst + cnt_w'(inc_inst) - cnt_w'(dec_inst);
            cnt_data <= cnt_data + cnt_w'(inc_data) - cnt_w'(dec_data);
        end
    end

    assign rready    = (cnt_inst != '0) || (cnt_data != '0);
    assign inst_full = (cnt_inst == '1);
    assign data_full = (cnt_data == '1);

    // one-cycle ok pulses follow each r beat
    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_data_ok      <= 1'b0;
            data_read_data_ok <= 1'b0;
        end else begin
            inst_data_ok      <= dec_inst;
            data_read_data_ok <= dec_data;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_inst) begin
            inst_rdata <= rdata;
        end
        if (dec_data) begin
            data_rdata <= rdata;
        end
    end

endmodule

`default_nettype wire

/* write_request.sv */
`timescale 1ns/1ps
`default_nettype none

module write_request
    import axi_pkg::*, bridge_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   data_en,
    input  logic                   data_wr,
    input  logic [sram_size_w-1:0] data_size,
    input  logic [strb_w-1:0]      data_wstrb,
    input  logic [addr_w-1:0]      data_addr,
    input  logic [data_w-1:0]      data_wdata,
    input  logic                   awready,
    input  logic                   wready,
    output logic [addr_w-1:0]      awaddr,
    output logic [size_w-1:0]      awsize,
    output logic                   awvalid,
    output logic [data_w-1:0]      wdata,
    output logic [strb_w-1:0]      wstrb,
    output logic                   wvalid,
    output logic                   w_fire,
    output logic                   data_write_addr_ok
);

    logic [2:0] state;
    logic [2:0] state_next;
    logic       take_write;
    logic       aw_fire;
    logic       aw_left;
    logic       w_left;

    assign take_write = data_en && data_wr;
    assign aw_fire    = awvalid && awready;
    assign w_fire     = wvalid && wready;

    // a channel is still owed if its valid is up and not taken this cycle
    assign aw_left = awvalid && !awready;
    assign w_left  = wvalid && !wready;

    always_comb begin
        state_next = state;
        case (state)
            wq_idle: begin
                if (take_write) begin
                    state_next = wq_issue;
                end
            end
            wq_issue: begin
                if (!aw_left && !w_left) begin
                    state_next = wq_done;
                end
            end
            wq_done: state_next = wq_idle;
            default: state_next = wq_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= wq_idle;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            state <= state_next;
            // both rise together, each falls on its own handshake
            if (state == wq_idle && take_write) begin
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
            end else begin
                if (aw_fire) begin
                    awvalid <= 1'b0;
                end
                if (w_fire) begin
                    wvalid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == wq_idle && take_write) begin
            awaddr <= data_addr;
            awsize <= {{(size_w-sram_size_w){1'b0}}, data_size};
            wdata  <= data_wdata;
            wstrb  <= data_wstrb;
        end
    end

    assign data_write_addr_ok = (state == wq_done);

endmodule

`default_nettype wire

/* write_response.sv */
`timescale 1ns/1ps
`default_nettype none

module write_response
    import bridge_pkg::*;
(
    input  logic clk,
    input  logic resetn,
    input  logic w_fire,
    input  logic bvalid,
    output logic bready,
    output logic write_busy,
    output logic data_write_data_ok
);

    logic [cnt_w-1:0] cnt_write;
    logic             b_fire;

    assign b_fire = bvalid && bready;

    // writes sent on w and not yet answered on b
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt_write <= '0;
        end else begin
            cnt_write <= cnt_write + cnt_w'(w_fire) - cnt_w'(b_fire);
        end
    end

    assign bready     = (cnt_write != '0);
    assign write_busy = (cnt_write != '0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            data_write_data_ok <= 1'b0;
        end else begin
            data_write_data_ok <= b_fire;
        end
    end

endmodule

`default_nettype wire

/* axi_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_bridge_top
    import axi_pkg::*, bridge_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,

    // instruction port
    input  logic                   inst_en,
    input  logic [sram_size_w-1:0] inst_size,
    input  logic [addr_w-1:0]      inst_addr,
    output logic [data_w-1:0]      inst_rdata,
    output logic                   inst_addr_ok,
    output logic                   inst_data_ok,

    // data port
    input  logic                   data_en,
    input  logic                   data_wr,
    input  logic [sram_size_w-1:0] data_size,
    input  logic [strb_w-1:0]      data_wstrb,
    input  logic [addr_w-1:0]      data_addr,
    input  logic [data_w-1:0]      data_wdata,
    output logic [data_w-1:0]      data_rdata,
    output logic                   data_addr_ok,
    output logic                   data_data_ok,

    // axi master
    output logic [id_w-1:0]        arid,
    output logic [addr_w-1:0]      araddr,
    output logic [size_w-1:0]      arsize,
    output logic                   arvalid,
    input  logic                   arready,
    input  logic [id_w-1:0]        rid,
    input  logic [data_w-1:0]      rdata,
    input  logic                   rvalid,
    output logic                   rready,
    output logic [addr_w-1:0]      awaddr,
    output logic [size_w-1:0]      awsize,
    output logic                   awvalid,
    input  logic                   awready,
    output logic [data_w-1:0]      wdata,
    output logic [strb_w-1:0]      wstrb,
    output logic                   wvalid,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready
);

    logic ar_fire;
    logic w_fire;
    logic write_busy;
    logic inst_full;
    logic data_full;
    logic data_read_addr_ok;
    logic data_read_data_ok;
    logic data_write_addr_ok;
    logic data_write_data_ok;

    read_request u_read_request (
        .clk               (clk),
        .resetn            (resetn),
        .inst_en           (inst_en),
        .inst_size         (inst_size),
        .inst_addr         (inst_addr),
        .data_en           (data_en),
        .data_wr           (data_wr),
        .data_size         (data_size),
        .data_addr         (data_addr),
        .write_busy        (write_busy),
        .inst_full         (inst_full),
        .data_full         (data_full),
        .arready           (arready),
        .arid              (arid),
        .araddr            (araddr),
        .arsize            (arsize),
        .arvalid           (arvalid),
        .ar_fire           (ar_fire),
        .inst_addr_ok      (inst_addr_ok),
        .data_read_addr_ok (data_read_addr_ok)
    );

    read_response u_read_response (
        .clk               (clk),
        .resetn            (resetn),
        .ar_fire           (ar_fire),
        .arid              (arid),
        .rid               (rid),
        .rdata             (rdata),
        .rvalid            (rvalid),
        .rready            (rready),
        .inst_full         (inst_full),
        .data_full         (data_full),
        .inst_rdata        (inst_rdata),
        .inst_data_ok      (inst_data_ok),
        .data_rdata        (data_rdata),
        .data_read_data_ok (data_read_data_ok)
    );

    write_request u_write_request (
        .clk                (clk),
        .resetn             (resetn),
        .data_en            (data_en),
        .data_wr            (data_wr),
        .data_size          (data_size),
        .data_wstrb         (data_wstrb),
        .data_addr          (data_addr),
        .data_wdata         (data_wdata),
        .awready            (awready),
        .wready             (wready),
        .awaddr             (awaddr),
        .awsize             (awsize),
        .awvalid            (awvalid),
        .wdata              (wdata),
        .wstrb              (wstrb),
        .wvalid             (wvalid),
        .w_fire             (w_fire),
        .data_write_addr_ok (data_write_addr_ok)
    );

    write_response u_write_response (
        .clk                (clk),
        .resetn             (resetn),
        .w_fire             (w_fire),
        .bvalid             (bvalid),
        .bready             (bready),
        .write_busy         (write_busy),
        .data_write_data_ok (data_write_data_ok)
    );

    // data port is serial, so read and write pulses never overlap
    assign data_addr_ok = data_read_addr_ok || data_write_addr_ok;
    assign data_data_ok = data_read_data_ok || data_write_data_ok;

endmodule

`default_nettype wire

/* axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model
    import axi_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic [id_w-1:0]   arid,
    input  logic [addr_w-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [id_w-1:0]   rid,
    output logic [data_w-1:0] rdata,
    output logic              rvalid,
    input  logic              rready,
    input  logic [addr_w-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [data_w-1:0] wdata,
    input  logic [strb_w-1:0] wstrb,
    input  logic              wvalid,
    output logic              wready,
    output logic              bvalid,
    input  logic              bready
);

    logic [data_w-1:0] mem [0:255];
    logic [addr_w-1:0] rq_addr [$];
    logic [id_w-1:0]   rq_id [$];
    logic [addr_w-1:0] head_addr;
    logic [addr_w-1:0] aw_addr_q;
    logic [data_w-1:0] w_data_q;
    logic [strb_w-1:0] w_strb_q;
    logic              aw_have;
    logic              w_have;
    integer            seed;
    integer            ar_wait;
    integer            r_wait;
    integer            aw_wait;
    integer            w_wait;
    integer            b_wait;
    integer            b_pend;

    // preload, every word differs in all index bits
    initial begin
        seed = 11028;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        end
    end

    always @(posedge clk) begin
        if (!resetn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            rq_addr.delete();
            rq_id.delete();
            aw_have = 1'b0;
            w_have  = 1'b0;
            ar_wait = 0;
            r_wait  = 0;
            aw_wait = 0;
            w_wait  = 0;
            b_wait  = 0;
            b_pend  = 0;
        end else begin
            // r before ar, so a read is answered one cycle after its ar at the earliest
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_wait = $unsigned($random(seed)) % 4;
            end else if (!rvalid && rq_addr.size() > 0) begin
                if (r_wait == 0) begin
                    head_addr = rq_addr[0];
                    rvalid <= 1'b1;
                    rid    <= rq_id[0];
                    rdata  <= mem[head_addr[9:2]];
                    void'(rq_addr.pop_front());
                    void'(rq_id.pop_front());
                end else begin
                    r_wait = r_wait - 1;
                end
            end
            if (arvalid && arready) begin
                arready <= 1'b0;
                rq_addr.push_back(araddr);
                rq_id.push_back(arid);
                ar_wait = $unsigned($random(seed)) % 4;
            end else if (arvalid) begin
                if (ar_wait == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait = ar_wait - 1;
                end
            end
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_addr_q = awaddr;
                aw_have = 1'b1;
                aw_wait = $unsigned($random(seed)) % 4;
            end else if (awvalid) begin
                if (aw_wait == 0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait = aw_wait - 1;
                end
            end
            if (wvalid && wready) begin
                wready <= 1'b0;
                w_data_q = wdata;
                w_strb_q = wstrb;
                w_have = 1'b1;
                w_wait = $unsigned($random(seed)) % 4;
            end else if (wvalid) begin
                if (w_wait == 0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait = w_wait - 1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_wait = $unsigned($random(seed)) % 4;
            end else if (!bvalid && b_pend > 0) begin
                if (b_wait == 0) begin
                    bvalid <= 1'b1;
                    b_pend = b_pend - 1;
                end else begin
                    b_wait = b_wait - 1;
                end
            end
            // write lands once address and data are both in
            if (aw_have && w_have) begin
                for (int b = 0; b < strb_w; b++) begin
                    if (w_strb_q[b]) begin
                        mem[aw_addr_q[9:2]][8*b +: 8] = w_data_q[8*b +: 8];
                    end
                end
                aw_have = 1'b0;
                w_have  = 1'b0;
                b_pend  = b_pend + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_axi_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_bridge
    import axi_pkg::*;
();

    localparam int wait_limit = 1000;

    logic              clk;
    logic              resetn;
    logic              inst_en;
    logic [1:0]        inst_size;
    logic [addr_w-1:0] inst_addr;
    logic [data_w-1:0] inst_rdata;
    logic              inst_addr_ok;
    logic              inst_data_ok;
    logic              data_en;
    logic              data_wr;
    logic [1:0]        data_size;
    logic [strb_w-1:0] data_wstrb;
    logic [addr_w-1:0] data_addr;
    logic [data_w-1:0] data_wdata;
    logic [data_w-1:0] data_rdata;
    logic              data_addr_ok;
    logic              data_data_ok;
    logic [id_w-1:0]   arid;
    logic [addr_w-1:0] araddr;
    logic [size_w-1:0] arsize;
    logic              arvalid;
    logic              arready;
    logic [id_w-1:0]   rid;
    logic [data_w-1:0] rdata;
    logic              rvalid;
    logic              rready;
    logic [addr_w-1:0] awaddr;
    logic [size_w-1:0] awsize;
    logic              awvalid;
    logic              awready;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    logic              bvalid;
    logic              bready;

    logic [data_w-1:0] ref_mem [0:255];
    logic [data_w-1:0] inst_exp [$];
    // top bit marks a read whose data must be compared
    logic [data_w:0]   data_exp [$];
    integer            seed;
    integer            errors;
    integer            tests_run;
    integer            tests_failed;
    integer            inst_acc;
    integer            inst_done;
    integer            data_acc;
    integer            data_done;

    axi_bridge_top u_axi_bridge_top (.*);

    axi_mem_model u_mem (
        .clk (clk), .resetn (resetn),
        .arid (arid), .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rid (rid), .rdata (rdata), .rvalid (rvalid), .rready (rready),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bvalid (bvalid), .bready (bready)
    );

    always #5 clk = ~clk;

    function automatic logic [data_w-1:0] merge_word(input logic [data_w-1:0] old_w,
                                                     input logic [data_w-1:0] new_w,
                                                     input logic [strb_w-1:0] strb);
        logic [data_w-1:0] m;
        m = old_w;
        for (int b = 0; b < strb_w; b++) begin
            if (strb[b]) begin
                m[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return m;
    endfunction

    // responses are matched in issue order per port
    always @(negedge clk) begin
        logic [data_w-1:0] ie;
        logic [data_w:0]   de;
        if (resetn && inst_data_ok) begin
            inst_done = inst_done + 1;
            if (inst_exp.size() == 0) begin
                $display("inst_data_ok at %0t with no read outstanding", $time);
                errors = errors + 1;
            end else begin
                ie = inst_exp.pop_front();
                if (inst_rdata !== ie) begin
                    $display("ERROR t=%0t inst_rdata got %h expected %h", $time, inst_rdata, ie);
                    errors = errors + 1;
                end
            end
        end
        if (resetn && data_data_ok) begin
            data_done = data_done + 1;
            if (data_exp.size() == 0) begin
                $display("data_data_ok at %0t with no request outstanding", $time);
                errors = errors + 1;
            end else begin
                de = data_exp.pop_front();
                if (de[data_w] && data_rdata !== de[data_w-1:0]) begin
                    $display("ERROR t=%0t data_rdata got %h expected %h",
                             $time, data_rdata, de[data_w-1:0]);
                    errors = errors + 1;
                end
            end
        end
    end

    // request sizes go out zero-extended
    always @(negedge clk) begin
        logic [size_w-1:0] size_exp;
        if (resetn && arvalid) begin
            if (arid !== id_inst && arid !== id_data) begin
                $display("ERROR t=%0t arid got %h expected %h or %h",
                         $time, arid, id_inst, id_data);
                errors = errors + 1;
            end
            size_exp = {1'b0, ((arid === id_data) ? data_size : inst_size)};
            if (arsize !== size_exp) begin
                $display("ERROR t=%0t arsize got %h expected %h", $time, arsize, size_exp);
                errors = errors + 1;
            end
        end
        if (resetn && awvalid) begin
            size_exp = {1'b0, data_size};
            if (awsize !== size_exp) begin
                $display("ERROR t=%0t awsize got %h expected %h", $time, awsize, size_exp);
                errors = errors + 1;
            end
        end
    end

    task automatic report_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        errors = errors + 1;
    endtask

    task automatic expect_low(input string name, input logic v);
        if (v !== 1'b0) begin
            $display("ERROR t=%0t %s got %b expected 0", $time, name, v);
            errors = errors + 1;
        end
    endtask

    task automatic check_idle_outputs();
        expect_low("arvalid", arvalid);
        expect_low("awvalid", awvalid);
        expect_low("wvalid", wvalid);
        expect_low("rready", rready);
        expect_low("bready", bready);
        expect_low("inst_addr_ok", inst_addr_ok);
        expect_low("inst_data_ok", inst_data_ok);
        expect_low("data_addr_ok", data_addr_ok);
        expect_low("data_data_ok", data_data_ok);
    endtask

    task automatic inst_read_burst(input int n);
        logic [addr_w-1:0] a;
        int                cnt;
        @(negedge clk);
        for (int k = 0; k < n; k++) begin
            a = $random(seed);
            a = {23'h0, a[6:0], 2'b00};
            inst_en   = 1'b1;
            inst_addr = a;
            cnt = 0;
            do begin
                @(negedge clk);
                cnt++;
            end while (!inst_addr_ok && cnt < wait_limit);
            if (!inst_addr_ok) begin
                report_timeout("inst_addr_ok");
                break;
            end
            inst_exp.push_back(ref_mem[a[9:2]]);
            inst_acc = inst_acc + 1;
        end
        inst_en = 1'b0;
    endtask

    task automatic drain_inst();
        int cnt;
        cnt = 0;
        while (inst_done < inst_acc && cnt < wait_limit) begin
            @(posedge clk);
            cnt++;
        end
        if (inst_done < inst_acc) begin
            report_timeout("inst_data_ok");
        end
    endtask

    task automatic drain_data();
        int cnt;
        cnt = 0;
        while (data_done < data_acc && cnt < wait_limit) begin
            @(posedge clk);
            cnt++;
        end
        if (data_done < data_acc) begin
            report_timeout("data_data_ok");
        end
    endtask

    task automatic data_access(input logic wr, input logic [addr_w-1:0] a,
                               input logic [strb_w-1:0] strb, input logic [data_w-1:0] wd);
        int cnt;
        @(negedge clk);
        data_en    = 1'b1;
        data_wr    = wr;
        data_addr  = a;
        data_wstrb = strb;
        data_wdata = wd;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!data_addr_ok && cnt < wait_limit);
        data_en = 1'b0;
        if (!data_addr_ok) begin
            report_timeout("data_addr_ok");
        end else begin
            if (wr) begin
                ref_mem[a[9:2]] = merge_word(ref_mem[a[9:2]], wd, strb);
                data_exp.push_back({1'b0, {data_w{1'b0}}});
            end else begin
                data_exp.push_back({1'b1, ref_mem[a[9:2]]});
            end
            data_acc = data_acc + 1;
            drain_data();
        end
    endtask

    task automatic random_data_op();
        logic [addr_w-1:0] a;
        logic [data_w-1:0] r;
        a = $random(seed);
        a = {22'h0, 1'b1, a[6:0], 2'b00};
        r = $random(seed);
        data_access(r[0], a, r[7:4], $random(seed));
    endtask

    task automatic end_test(input string name, input int base);
        tests_run = tests_run + 1;
        if (errors == base) begin
            $display("test %s passed", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s failed with %0d errors", name, errors - base);
        end
    endtask

    initial begin
        int                base;
        int                cnt;
        logic              got_d;
        logic              got_i;
        logic [addr_w-1:0] a;
        logic [data_w-1:0] r;
        seed = 11028;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        inst_acc = 0;
        inst_done = 0;
        data_acc = 0;
        data_done = 0;
        clk = 1'b0;
        resetn = 1'b0;
        inst_en = 1'b0;
        inst_size = 2'd2;
        inst_addr = '0;
        data_en = 1'b0;
        data_wr = 1'b0;
        data_size = 2'd2;
        data_wstrb = '0;
        data_addr = '0;
        data_wdata = '0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        end

        base = errors;
        repeat (4) begin
            @(negedge clk);
            check_idle_outputs();
        end
        resetn = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        end_test("reset", base);

        base = errors;
        inst_read_burst(3);
        drain_inst();
        inst_read_burst(7);
        drain_inst();
        end_test("inst_reads", base);

        base = errors;
        for (int k = 0; k < 8; k++) begin
            a = $random(seed);
            a = {22'h0, 1'b1, a[6:0], 2'b00};
            r = $random(seed);
            data_access(1'b1, a, r[3:0], $random(seed));
            data_access(1'b0, a, 4'h0, '0);
        end
        end_test("write_then_read", base);

        base = errors;
        fork
            inst_read_burst(24);
            for (int k = 0; k < 14; k++) begin
                random_data_op();
            end
        join
        drain_inst();
        drain_data();
        if (inst_acc != inst_done || data_acc != data_done) begin
            $display("ok counts differ: inst %0d/%0d data %0d/%0d",
                     inst_acc, inst_done, data_acc, data_done);
            errors = errors + 1;
        end
        end_test("mixed", base);

        // data read and instruction read raised together
        base = errors;
        @(negedge clk);
        a = {22'h0, 1'b1, 7'h15, 2'b00};
        data_en = 1'b1;
        data_wr = 1'b0;
        data_addr = a;
        inst_en = 1'b1;
        inst_addr = {23'h0, 7'h2a, 2'b00};
        got_d = 1'b0;
        got_i = 1'b0;
        cnt = 0;
        while (!(got_d && got_i) && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
            if (data_addr_ok && !got_d) begin
                got_d = 1'b1;
                data_en = 1'b0;
                data_exp.push_back({1'b1, ref_mem[a[9:2]]});
                data_acc = data_acc + 1;
            end
            if (inst_addr_ok && !got_i) begin
                if (!got_d) begin
                    $display("inst_addr_ok came before data_addr_ok at %0t", $time);
                    errors = errors + 1;
                end
                got_i = 1'b1;
                inst_en = 1'b0;
                inst_exp.push_back(ref_mem[inst_addr[9:2]]);
                inst_acc = inst_acc + 1;
            end
        end
        data_en = 1'b0;
        inst_en = 1'b0;
        if (!(got_d && got_i)) begin
            report_timeout("both addr_ok pulses");
        end
        drain_data();
        drain_inst();
        end_test("arbitration", base);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
axi_pkg.sv
bridge_pkg.sv
read_request.sv
read_response.sv
write_request.sv
write_response.sv
axi_bridge_top.sv
axi_mem_model.sv
tb_axi_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f tb.f --top-module tb_axi_bridge -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
exit 1
